//--- sim.f
+incdir+bench
verilog/core_pkg.sv
verilog/rename_unit.sv
verilog/phys_regfile.sv
verilog/issue_queue.sv
verilog/alu_unit.sv
verilog/mult_unit.sv
verilog/cdb_arbiter.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
bench/tb_core.sv

//--- Makefile
# Verilator build and run of the core bench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard bench/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG) || \
		! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/core_model.svh
////////////////////////////////////////
// Random source, reference model and compare task
// Included inside the bench module body
////////////////////////////////////////
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Xorshift state, fixed seed
logic [31:0] rng_state = 32'd8;

// Architectural registers in program order
data_t arch_regs [NUM_ARCH_REGS];

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// All registers read zero after reset
function automatic void model_reset();
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        arch_regs[i] = '0;
    end
endfunction

// One accepted instruction, returns the new value of rd
function automatic data_t model_execute(input opcode_t op, input arch_reg_t rd,
                                        input arch_reg_t rs1, input arch_reg_t rs2,
                                        input imm_t imm);
    data_t a;
    data_t b;
    data_t r;
    a = arch_regs[rs1];
    b = arch_regs[rs2];
    case (op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_XOR:  r = a ^ b;
        // Low half of the product only
        OP_MUL:  r = a * b;
        default: r = {24'd0, imm};
    endcase
    arch_regs[rd] = r;
    return r;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        errors++;
        abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                            name, actual, expected));
    end
endtask

`endif

//--- bench/tb_core.sv
////////////////////////////////////////
// Random instruction bench for the core
// Checks every retire against the model
////////////////////////////////////////
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam int NUM_INSTS       = 400;
    localparam int WATCHDOG_CYCLES = NUM_INSTS * 20;
    // Up to here, MUL then ADD of its result
    localparam int CHAIN_LAST      = 47;

    logic      clock;
    logic      rst;
    logic      inst_valid;
    opcode_t   inst_op;
    arch_reg_t inst_rd;
    arch_reg_t inst_rs1;
    arch_reg_t inst_rs2;
    imm_t      inst_imm;
    logic      inst_ready;
    logic      retire_valid;
    arch_reg_t retire_rd;
    data_t     retire_data;

    int        errors   = 0;
    int        accepted = 0;
    int        retired  = 0;
    arch_reg_t last_mul_rd;

    // Expected retires, oldest first
    arch_reg_t exp_rd   [$];
    data_t     exp_data [$];

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    `include "core_model.svh"

    ooo_core uut (
        .clock(clock), .rst(rst),
        .inst_valid(inst_valid), .inst_op(inst_op), .inst_rd(inst_rd),
        .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .inst_imm(inst_imm),
        .inst_ready(inst_ready),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    ////////////////////////////////////////
    // Instruction picker and driver
    ////////////////////////////////////////
    task automatic drive_instruction(input int n);
        logic [31:0] r;
        opcode_t     op;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        imm_t        imm;
        r   = xorshift32();
        rd  = r[2:0];
        rs1 = r[5:3];
        rs2 = r[8:6];
        imm = r[16:9];
        if (n == 0) begin
            // r1 = r0 + r0, must retire zero
            op  = OP_ADD;
            rd  = 3'd1;
            rs1 = 3'd0;
            rs2 = 3'd0;
        end else if (n < NUM_ARCH_REGS) begin
            // Seed registers with nonzero values
            op = OP_LDI;
            rd = arch_reg_t'(n);
        end else if (n <= CHAIN_LAST) begin
            if (n % 2 == 0) begin
                op          = OP_MUL;
                last_mul_rd = rd;
            end else begin
                // Consumer of the multiplier result
                op  = OP_ADD;
                rs1 = last_mul_rd;
            end
        end else if ((r[31:20] % 12'd5) == 12'd0) begin
            op = OP_LDI;
        end else begin
            // ADD, SUB, XOR or MUL
            op = opcode_t'(r[18:17]);
        end
        inst_valid <= 1'b1;
        inst_op    <= op;
        inst_rd    <= rd;
        inst_rs1   <= rs1;
        inst_rs2   <= rs2;
        inst_imm   <= imm;
    endtask

    // Valid held high, new instruction only after acceptance
    initial begin : stimulus
        int   stalls;
        logic take;
        stalls      = 0;
        last_mul_rd = '0;
        rst        <= 1'b1;
        inst_valid <= 1'b0;
        inst_op    <= OP_ADD;
        inst_rd    <= '0;
        inst_rs1   <= '0;
        inst_rs2   <= '0;
        inst_imm   <= '0;
        model_reset();
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        drive_instruction(0);
        while (accepted < NUM_INSTS) begin
            @(negedge clock);
            take = inst_valid && inst_ready;
            if (inst_valid && !inst_ready) begin
                stalls++;
            end
            @(posedge clock);
            if (take) begin
                exp_rd.push_back(inst_rd);
                exp_data.push_back(model_execute(inst_op, inst_rd, inst_rs1,
                                                 inst_rs2, inst_imm));
                accepted++;
                if (accepted < NUM_INSTS) begin
                    drive_instruction(accepted);
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end
        // Drain, then a few idle cycles to catch stray retires
        while (retired < NUM_INSTS) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);
        check_value("inst_ready_low_seen", 32'(stalls != 0), 32'd1);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Retire checker
    ////////////////////////////////////////
    initial begin : retire_monitor
        forever begin
            @(negedge clock);
            if (exp_rd.size() == 0) begin
                // Nothing outstanding
                check_value("retire_valid", 32'(retire_valid), 32'h0);
            end else if (retire_valid === 1'b1) begin
                check_value("retire_rd", 32'(retire_rd), 32'(exp_rd.pop_front()));
                check_value("retire_data", retire_data, exp_data.pop_front());
                retired++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run($sformatf("Watchdog expired after %0d cycles, %0d of %0d retired",
                            WATCHDOG_CYCLES, retired, NUM_INSTS));
    end

endmodule

//--- verilog/ooo_core.sv
////////////////////////////////////////
// Out-of-order core top, valid/ready instruction input
// In-order retire port, no back-pressure on retire
////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core (
    input  logic                clock,
    input  logic                rst,
    input  logic                inst_valid,
    input  core_pkg::opcode_t   inst_op,
    input  core_pkg::arch_reg_t inst_rd,
    input  core_pkg::arch_reg_t inst_rs1,
    input  core_pkg::arch_reg_t inst_rs2,
    input  core_pkg::imm_t      inst_imm,
    output logic                inst_ready,
    output logic                retire_valid,
    output core_pkg::arch_reg_t retire_rd,
    output core_pkg::data_t     retire_data
);
    import core_pkg::*;

    // Dispatch side
    logic      dispatch;
    logic      rob_full;
    logic      iq_full;
    logic      free_avail;
    logic      src1_ready;
    logic      src2_ready;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    rob_idx_t  alloc_slot;

    // Issue side
    logic      issue_alu;
    logic      issue_mult;
    opcode_t   issue_op;
    imm_t      issue_imm;
    phys_tag_t issue_tag;
    rob_idx_t  issue_rob;
    phys_tag_t opnd_tag_a;
    phys_tag_t opnd_tag_b;
    data_t     opnd_a;
    data_t     opnd_b;
    data_t     issue_a;
    data_t     issue_b;

    // Units and bus
    logic      alu_busy;
    logic      alu_req;
    logic      gnt_alu;
    phys_tag_t alu_tag;
    rob_idx_t  alu_rob;
    data_t     alu_data;
    logic      mult_busy;
    logic      mult_req;
    logic      gnt_mult;
    phys_tag_t mult_tag;
    rob_idx_t  mult_rob;
    data_t     mult_data;
    logic      cdb_valid;
    phys_tag_t cdb_tag;
    rob_idx_t  cdb_rob_idx;
    data_t     cdb_data;

    // Retire side
    phys_tag_t retire_tag;
    logic      free_valid;
    phys_tag_t free_tag;

    // Stall when any of ROB, queue or free list has no room
    assign inst_ready = !rob_full && !iq_full && free_avail;
    assign dispatch   = inst_valid && inst_ready;

    ////////////////////////////////////////
    // Rename and register state
    ////////////////////////////////////////
    rename_unit u_rename (
        .clock(clock), .rst(rst), .dispatch(dispatch),
        .inst_rd(inst_rd), .inst_rs1(inst_rs1), .inst_rs2(inst_rs2),
        .free_valid(free_valid), .free_tag(free_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .new_tag(new_tag), .old_tag(old_tag), .free_avail(free_avail)
    );

    phys_regfile u_prf (
        .clock(clock), .rst(rst),
        .alloc_valid(dispatch), .alloc_tag(new_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .rd_tag_a(opnd_tag_a), .rd_tag_b(opnd_tag_b), .rd_tag_r(retire_tag),
        .chk_tag_a(src1_tag), .chk_tag_b(src2_tag),
        .rd_data_a(opnd_a), .rd_data_b(opnd_b), .rd_data_r(retire_data),
        .chk_ready_a(src1_ready), .chk_ready_b(src2_ready)
    );

    ////////////////////////////////////////
    // Issue and execute
    ////////////////////////////////////////
    issue_queue u_iq (
        .clock(clock), .rst(rst), .dispatch(dispatch),
        .inst_op(inst_op), .inst_imm(inst_imm),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .new_tag(new_tag), .rob_slot(alloc_slot),
        .alu_busy(alu_busy), .mult_busy(mult_busy),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .iq_full(iq_full),
        .opnd_tag_a(opnd_tag_a), .opnd_tag_b(opnd_tag_b),
        .issue_alu(issue_alu), .issue_mult(issue_mult),
        .issue_op(issue_op), .issue_imm(issue_imm),
        .issue_tag(issue_tag), .issue_rob(issue_rob),
        .issue_a(issue_a), .issue_b(issue_b)
    );

    alu_unit u_alu (
        .clock(clock), .rst(rst), .start(issue_alu),
        .op(issue_op), .imm(issue_imm), .tag(issue_tag), .rob(issue_rob),
        .a(issue_a), .b(issue_b), .gnt(gnt_alu),
        .busy(alu_busy), .req(alu_req),
        .res_tag(alu_tag), .res_rob(alu_rob), .res_data(alu_data)
    );

    mult_unit u_mult (
        .clock(clock), .rst(rst), .start(issue_mult),
        .tag(issue_tag), .rob(issue_rob),
        .a(issue_a), .b(issue_b), .gnt(gnt_mult),
        .busy(mult_busy), .req(mult_req),
        .res_tag(mult_tag), .res_rob(mult_rob), .res_data(mult_data)
    );

    ////////////////////////////////////////
    // Broadcast and retire
    ////////////////////////////////////////
    cdb_arbiter u_arb (
        .clock(clock), .rst(rst),
        .req_alu(alu_req), .req_mult(mult_req),
        .alu_tag(alu_tag), .alu_rob(alu_rob), .alu_data(alu_data),
        .mult_tag(mult_tag), .mult_rob(mult_rob), .mult_data(mult_data),
        .gnt_alu(gnt_alu), .gnt_mult(gnt_mult),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_rob_idx(cdb_rob_idx), .cdb_data(cdb_data)
    );

    reorder_buffer u_rob (
        .clock(clock), .rst(rst), .dispatch(dispatch),
        .inst_rd(inst_rd), .new_tag(new_tag), .old_tag(old_tag),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx),
        .rob_full(rob_full), .alloc_slot(alloc_slot),
        .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_tag(retire_tag), .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

//--- verilog/reorder_buffer.sv
////////////////////////////////////////
// Circular reorder buffer, completes from the CDB
// Retires the head in program order
////////////////////////////////////////
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                clock,
    input  logic                rst,
    input  logic                dispatch,
    input  core_pkg::arch_reg_t inst_rd,
    input  core_pkg::phys_tag_t new_tag,
    input  core_pkg::phys_tag_t old_tag,
    input  logic                cdb_valid,
    input  core_pkg::rob_idx_t  cdb_rob_idx,
    output logic                rob_full,
    output core_pkg::rob_idx_t  alloc_slot,
    output logic                retire_valid,
    output core_pkg::arch_reg_t retire_rd,
    output core_pkg::phys_tag_t retire_tag,
    output logic                free_valid,
    output core_pkg::phys_tag_t free_tag
);
    import core_pkg::*;

    // Per-slot payload
    arch_reg_t rd_q  [ROB_DEPTH];
    phys_tag_t new_q [ROB_DEPTH];
    phys_tag_t old_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0]       done;
    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic [$clog2(ROB_DEPTH):0] count;

    assign rob_full   = (count == $bits(count)'(ROB_DEPTH));
    assign alloc_slot = tail;

    ////////////////////////////////////////
    // Retire port, head leaves on this edge
    ////////////////////////////////////////
    assign retire_valid = (count != '0) && done[head];
    assign retire_rd    = rd_q[head];
    assign retire_tag   = new_q[head];
    // Previous mapping of rd is dead once rd commits
    assign free_valid   = retire_valid;
    assign free_tag     = old_q[head];

    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_rob_idx] <= 1'b1;
            end
            if (dispatch) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            case ({dispatch, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            rd_q[tail]  <= inst_rd;
            new_q[tail] <= new_tag;
            old_q[tail] <= old_tag;
        end
    end

endmodule

//--- verilog/cdb_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter for the ALU and multiplier on the CDB
////////////////////////////////////////
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                clock,
    input  logic                rst,
    input  logic                req_alu,
    input  logic                req_mult,
    input  core_pkg::phys_tag_t alu_tag,
    input  core_pkg::rob_idx_t  alu_rob,
    input  core_pkg::data_t     alu_data,
    input  core_pkg::phys_tag_t mult_tag,
    input  core_pkg::rob_idx_t  mult_rob,
    input  core_pkg::data_t     mult_data,
    output logic                gnt_alu,
    output logic                gnt_mult,
    output logic                cdb_valid,
    output core_pkg::phys_tag_t cdb_tag,
    output core_pkg::rob_idx_t  cdb_rob_idx,
    output core_pkg::data_t     cdb_data
);
    // Set when the ALU won last, ALU first after reset
    logic last_alu;

    // On a tie the previous loser wins
    assign gnt_alu  = req_alu && (!req_mult || !last_alu);
    assign gnt_mult = req_mult && !gnt_alu;

    ////////////////////////////////////////
    // Bus drive from the winner
    ////////////////////////////////////////
    assign cdb_valid   = req_alu || req_mult;
    assign cdb_tag     = gnt_alu ? alu_tag  : mult_tag;
    assign cdb_rob_idx = gnt_alu ? alu_rob  : mult_rob;
    assign cdb_data    = gnt_alu ? alu_data : mult_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            last_alu <= 1'b0;
        end else if (gnt_alu) begin
            last_alu <= 1'b1;
        end else if (gnt_mult) begin
            last_alu <= 1'b0;
        end
    end

endmodule

//--- verilog/mult_unit.sv
////////////////////////////////////////
// Multi-cycle multiplier, low 32 bits of the product
// Requests the CDB MULT_LATENCY cycles after issue
////////////////////////////////////////
`timescale 1ns/1ps

module mult_unit (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  core_pkg::phys_tag_t tag,
    input  core_pkg::rob_idx_t  rob,
    input  core_pkg::data_t     a,
    input  core_pkg::data_t     b,
    input  logic                gnt,
    output logic                busy,
    output logic                req,
    output core_pkg::phys_tag_t res_tag,
    output core_pkg::rob_idx_t  res_rob,
    output core_pkg::data_t     res_data
);
    import core_pkg::*;

    // Cycles left before the result is offered
    logic [$clog2(MULT_LATENCY+1)-1:0] cnt;
    data_t                             mul_a;
    data_t                             mul_b;

    assign req      = busy && (cnt == '0);
    // Product truncated to the register width
    assign res_data = mul_a * mul_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= $bits(cnt)'(MULT_LATENCY - 1);
        end else if (busy) begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (gnt) begin
                busy <= 1'b0;
            end
        end
    end

    // Operands and result tags held for the whole op
    always_ff @(posedge clock) begin
        if (start) begin
            mul_a   <= a;
            mul_b   <= b;
            res_tag <= tag;
            res_rob <= rob;
        end
    end

endmodule

//--- verilog/alu_unit.sv
////////////////////////////////////////
// Single-cycle ALU, holds its result until the CDB grant
////////////////////////////////////////
`timescale 1ns/1ps

module alu_unit (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  core_pkg::opcode_t   op,
    input  core_pkg::imm_t      imm,
    input  core_pkg::phys_tag_t tag,
    input  core_pkg::rob_idx_t  rob,
    input  core_pkg::data_t     a,
    input  core_pkg::data_t     b,
    input  logic                gnt,
    output logic                busy,
    output logic                req,
    output core_pkg::phys_tag_t res_tag,
    output core_pkg::rob_idx_t  res_rob,
    output core_pkg::data_t     res_data
);
    import core_pkg::*;

    // Result is ready one edge after start
    assign req = busy;

    // Busy from issue edge to grant edge
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (gnt) begin
            busy <= 1'b0;
        end
    end

    // Holding register
    always_ff @(posedge clock) begin
        if (start) begin
            res_tag <= tag;
            res_rob <= rob;
            case (op)
                OP_SUB:  res_data <= a - b;
                OP_XOR:  res_data <= a ^ b;
                OP_LDI:  res_data <= data_t'(imm);
                default: res_data <= a + b;
            endcase
        end
    end

endmodule

//--- verilog/issue_queue.sv
////////////////////////////////////////
// Shared reservation station, wakes from the CDB
// Issues the lowest ready entry to an idle unit
////////////////////////////////////////
`timescale 1ns/1ps

module issue_queue (
    input  logic                clock,
    input  logic                rst,
    input  logic                dispatch,
    input  core_pkg::opcode_t   inst_op,
    input  core_pkg::imm_t      inst_imm,
    input  core_pkg::phys_tag_t src1_tag,
    input  core_pkg::phys_tag_t src2_tag,
    input  logic                src1_ready,
    input  logic                src2_ready,
    input  core_pkg::phys_tag_t new_tag,
    input  core_pkg::rob_idx_t  rob_slot,
    input  logic                alu_busy,
    input  logic                mult_busy,
    input  logic                cdb_valid,
    input  core_pkg::phys_tag_t cdb_tag,
    input  core_pkg::data_t     opnd_a,
    input  core_pkg::data_t     opnd_b,
    output logic                iq_full,
    output core_pkg::phys_tag_t opnd_tag_a,
    output core_pkg::phys_tag_t opnd_tag_b,
    output logic                issue_alu,
    output logic                issue_mult,
    output core_pkg::opcode_t   issue_op,
    output core_pkg::imm_t      issue_imm,
    output core_pkg::phys_tag_t issue_tag,
    output core_pkg::rob_idx_t  issue_rob,
    output core_pkg::data_t     issue_a,
    output core_pkg::data_t     issue_b
);
    import core_pkg::*;

    // Entry state
    logic [IQ_DEPTH-1:0] vld;
    logic [IQ_DEPTH-1:0] rdy1;
    logic [IQ_DEPTH-1:0] rdy2;
    opcode_t             op_q  [IQ_DEPTH];
    imm_t                imm_q [IQ_DEPTH];
    phys_tag_t           s1_q  [IQ_DEPTH];
    phys_tag_t           s2_q  [IQ_DEPTH];
    phys_tag_t           dst_q [IQ_DEPTH];
    rob_idx_t            rob_q [IQ_DEPTH];

    logic [$clog2(IQ_DEPTH)-1:0] ins_idx;
    logic [$clog2(IQ_DEPTH)-1:0] sel_idx;
    logic                        sel_found;
    logic                        is_ldi;

    assign iq_full = &vld;
    // Immediate load has no sources to wait for
    assign is_ldi  = (inst_op == OP_LDI);

    // Lowest empty entry takes the new instruction
    always_comb begin
        ins_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!vld[i]) begin
                ins_idx = ($clog2(IQ_DEPTH))'(i);
            end
        end
    end

    // Lowest ready entry whose unit is idle
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!sel_found && vld[i] && rdy1[i] && rdy2[i] &&
                ((op_q[i] == OP_MUL) ? !mult_busy : !alu_busy)) begin
                sel_found = 1'b1;
                sel_idx   = ($clog2(IQ_DEPTH))'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Issue port, values from the regfile
    ////////////////////////////////////////
    assign issue_mult = sel_found && (op_q[sel_idx] == OP_MUL);
    assign issue_alu  = sel_found && (op_q[sel_idx] != OP_MUL);
    assign opnd_tag_a = s1_q[sel_idx];
    assign opnd_tag_b = s2_q[sel_idx];
    assign issue_op   = op_q[sel_idx];
    assign issue_imm  = imm_q[sel_idx];
    assign issue_tag  = dst_q[sel_idx];
    assign issue_rob  = rob_q[sel_idx];
    assign issue_a    = opnd_a;
    assign issue_b    = opnd_b;

    // Issued slot and dispatched slot never coincide
    always_ff @(posedge clock) begin
        if (rst) begin
            vld <= '0;
        end else begin
            if (sel_found) begin
                vld[sel_idx] <= 1'b0;
            end
            if (dispatch) begin
                vld[ins_idx] <= 1'b1;
            end
        end
    end

    // Wakeup on tag match, then fill of the new entry
    always_ff @(posedge clock) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (cdb_valid && (s1_q[i] == cdb_tag)) begin
                rdy1[i] <= 1'b1;
            end
            if (cdb_valid && (s2_q[i] == cdb_tag)) begin
                rdy2[i] <= 1'b1;
            end
        end
        if (dispatch) begin
            op_q[ins_idx]  <= inst_op;
            imm_q[ins_idx] <= inst_imm;
            s1_q[ins_idx]  <= src1_tag;
            s2_q[ins_idx]  <= src2_tag;
            dst_q[ins_idx] <= new_tag;
            rob_q[ins_idx] <= rob_slot;
            // Ready checks already count a same-cycle broadcast
            rdy1[ins_idx]  <= is_ldi || src1_ready;
            rdy2[ins_idx]  <= is_ldi || src2_ready;
        end
    end

endmodule

//--- verilog/phys_regfile.sv
////////////////////////////////////////
// Physical register values and ready bits
// Written from the CDB, three read ports and two ready checks
////////////////////////////////////////
`timescale 1ns/1ps

module phys_regfile (
    input  logic                clock,
    input  logic                rst,
    input  logic                alloc_valid,
    input  core_pkg::phys_tag_t alloc_tag,
    input  logic                cdb_valid,
    input  core_pkg::phys_tag_t cdb_tag,
    input  core_pkg::data_t     cdb_data,
    input  core_pkg::phys_tag_t rd_tag_a,
    input  core_pkg::phys_tag_t rd_tag_b,
    input  core_pkg::phys_tag_t rd_tag_r,
    input  core_pkg::phys_tag_t chk_tag_a,
    input  core_pkg::phys_tag_t chk_tag_b,
    output core_pkg::data_t     rd_data_a,
    output core_pkg::data_t     rd_data_b,
    output core_pkg::data_t     rd_data_r,
    output logic                chk_ready_a,
    output logic                chk_ready_b
);
    import core_pkg::*;

    data_t                    regs [NUM_PHYS_REGS];
    logic [NUM_PHYS_REGS-1:0] ready;

    // Operand ports for issue, third port for retire
    assign rd_data_a = regs[rd_tag_a];
    assign rd_data_b = regs[rd_tag_b];
    assign rd_data_r = regs[rd_tag_r];

    // Broadcast this cycle counts as ready
    assign chk_ready_a = ready[chk_tag_a] || (cdb_valid && (cdb_tag == chk_tag_a));
    assign chk_ready_b = ready[chk_tag_b] || (cdb_valid && (cdb_tag == chk_tag_b));

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            // A free tag is never on the bus, so no write order issue
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (cdb_valid) begin
                regs[cdb_tag]  <= cdb_data;
                ready[cdb_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/rename_unit.sv
////////////////////////////////////////
// Map table and free list, renames one instruction per dispatch
////////////////////////////////////////
`timescale 1ns/1ps

module rename_unit (
    input  logic                clock,
    input  logic                rst,
    input  logic                dispatch,
    input  core_pkg::arch_reg_t inst_rd,
    input  core_pkg::arch_reg_t inst_rs1,
    input  core_pkg::arch_reg_t inst_rs2,
    input  logic                free_valid,
    input  core_pkg::phys_tag_t free_tag,
    output core_pkg::phys_tag_t src1_tag,
    output core_pkg::phys_tag_t src2_tag,
    output core_pkg::phys_tag_t new_tag,
    output core_pkg::phys_tag_t old_tag,
    output logic                free_avail
);
    import core_pkg::*;

    // Current tag of each architectural register
    phys_tag_t map_tbl [NUM_ARCH_REGS];
    // Set while the tag is unallocated
    logic [NUM_PHYS_REGS-1:0] free_mask;

    // Sources see the mapping before this instruction's rd update
    assign src1_tag   = map_tbl[inst_rs1];
    assign src2_tag   = map_tbl[inst_rs2];
    assign old_tag    = map_tbl[inst_rd];
    assign free_avail = |free_mask;

    // Scan from the top so the lowest free tag wins
    always_comb begin
        new_tag = '0;
        for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                new_tag = phys_tag_t'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            // Identity map, upper half of the tags free
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_tbl[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                free_mask[i] <= (i >= NUM_ARCH_REGS);
            end
        end else begin
            if (dispatch) begin
                map_tbl[inst_rd]   <= new_tag;
                free_mask[new_tag] <= 1'b0;
            end
            // Retired old mapping goes back, never equal to new_tag
            if (free_valid) begin
                free_mask[free_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/core_pkg.sv
////////////////////////////////////////
// Widths, sizes, latency and opcodes for the core
// Imported by every RTL block and the bench
////////////////////////////////////////

package core_pkg;

    ////////////////////////////////////////
    // Machine sizes
    ////////////////////////////////////////
    localparam int NUM_ARCH_REGS = 8;
    localparam int NUM_PHYS_REGS = 16;
    localparam int ROB_DEPTH     = 8;
    localparam int IQ_DEPTH      = 4;
    // Issue to bus request, in cycles
    localparam int MULT_LATENCY  = 3;

    ////////////////////////////////////////
    // Value and index types
    ////////////////////////////////////////
    typedef logic [31:0] data_t;
    typedef logic [2:0]  arch_reg_t;
    typedef logic [3:0]  phys_tag_t;
    typedef logic [2:0]  rob_idx_t;
    // Zero-extended when used
    typedef logic [7:0]  imm_t;

    // Private instruction format, rd <= rs1 op rs2 or rd <= imm
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        OP_LDI = 3'd4
    } opcode_t;

endpackage
